// ==== simple_sys_config.svh ====
`ifndef SIMPLE_SYS_CONFIG_SVH
`define SIMPLE_SYS_CONFIG_SVH

// SRAM depth in 32-bit words
`define RAM_WORDS 1024

// SRAM window, 4 kB
`define RAM_BASE 32'h0010_0000
`define RAM_MASK 32'hFFFF_F000

// Machine timer window, 1 kB
`define TIMER_BASE 32'h0003_0000
`define TIMER_MASK 32'hFFFF_FC00

`endif

// ==== simple_sys_pkg.sv ====
package simple_sys_pkg;

  `include "simple_sys_config.svh"

  localparam int unsigned RAM_IDX_W = $clog2(`RAM_WORDS);

  // Timer register byte offsets inside the window
  localparam logic [9:0] MTIME_LO    = 10'h000;
  localparam logic [9:0] MTIME_HI    = 10'h004;
  localparam logic [9:0] MTIMECMP_LO = 10'h008;
  localparam logic [9:0] MTIMECMP_HI = 10'h00C;

  // Address as seen by the SRAM
  typedef struct packed {
    logic [29-RAM_IDX_W:0] tag;
    logic [RAM_IDX_W-1:0]  idx;
    logic [1:0]            off;
  } ram_addr_t;

  // Address as seen by a register block
  typedef struct packed {
    logic [21:0] tag;
    logic [7:0]  word;
    logic [1:0]  off;
  } reg_addr_t;

  typedef union packed {
    ram_addr_t ram;
    reg_addr_t regs;
  } bus_addr_u;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    bus_addr_u   addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

endpackage

// ==== sram_word.sv ====
`timescale 1ns/1ps

`include "simple_sys_config.svh"

module sram_word (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  simple_sys_pkg::bus_req_t req_i,
  output simple_sys_pkg::bus_rsp_t rsp_o
);

  import simple_sys_pkg::*;

  logic [31:0]          mem [`RAM_WORDS];
  logic [RAM_IDX_W-1:0] idx;
  logic                 rvalid_q;
  logic [31:0]          rdata_q;

  assign idx = req_i.addr.ram.idx;

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (req_i.be[i]) begin
          mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= mem[idx];
    end else begin
      rdata_q <= '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

endmodule

// ==== mtimer.sv ====
`timescale 1ns/1ps

module mtimer (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  simple_sys_pkg::bus_req_t req_i,
  output simple_sys_pkg::bus_rsp_t rsp_o,
  output logic                     timer_irq_o
);

  import simple_sys_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic [9:0]  reg_off;
  logic        sel_time_lo;
  logic        sel_time_hi;
  logic        sel_cmp_lo;
  logic        sel_cmp_hi;
  logic        known;
  logic        wr;
  logic [31:0] rd_word;
  logic        irq_q;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Byte offset of the addressed register
  assign reg_off     = {req_i.addr.regs.word, 2'b00};
  assign sel_time_lo = (reg_off == MTIME_LO);
  assign sel_time_hi = (reg_off == MTIME_HI);
  assign sel_cmp_lo  = (reg_off == MTIMECMP_LO);
  assign sel_cmp_hi  = (reg_off == MTIMECMP_HI);
  assign known       = sel_time_lo | sel_time_hi | sel_cmp_lo | sel_cmp_hi;
  assign wr          = req_i.req & req_i.we & known;

  // Count holds during a load, then resumes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
    end else if (wr && sel_time_lo) begin
      mtime_q[31:0] <= merge_bytes(mtime_q[31:0], req_i.wdata, req_i.be);
    end else if (wr && sel_time_hi) begin
      mtime_q[63:32] <= merge_bytes(mtime_q[63:32], req_i.wdata, req_i.be);
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // All ones keeps the interrupt quiet out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtimecmp_q <= '1;
    end else if (wr && sel_cmp_lo) begin
      mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], req_i.wdata, req_i.be);
    end else if (wr && sel_cmp_hi) begin
      mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], req_i.wdata, req_i.be);
    end
  end

  always_comb begin
    case (reg_off)
      MTIME_LO:    rd_word = mtime_q[31:0];
      MTIME_HI:    rd_word = mtime_q[63:32];
      MTIMECMP_LO: rd_word = mtimecmp_q[31:0];
      MTIMECMP_HI: rd_word = mtimecmp_q[63:32];
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      irq_q    <= (mtime_q >= mtimecmp_q);
      rvalid_q <= req_i.req;
      err_q    <= req_i.req & ~known;
    end
  end

  // Zero data for writes and bad offsets
  always_ff @(posedge clk_i) begin
    rdata_q <= (req_i.req && !req_i.we) ? rd_word : '0;
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;
  assign timer_irq_o  = irq_q;

endmodule

// ==== bus_decode.sv ====
`timescale 1ns/1ps

`include "simple_sys_config.svh"

module bus_decode (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  simple_sys_pkg::bus_req_t host_req_i,
  output simple_sys_pkg::bus_rsp_t host_rsp_o,
  output simple_sys_pkg::bus_req_t ram_req_o,
  input  simple_sys_pkg::bus_rsp_t ram_rsp_i,
  output simple_sys_pkg::bus_req_t timer_req_o,
  input  simple_sys_pkg::bus_rsp_t timer_rsp_i
);

  import simple_sys_pkg::*;

  logic [31:0] addr;
  logic        ram_hit;
  logic        timer_hit;
  logic        sel_ram_q;
  logic        sel_timer_q;
  logic        miss_q;

  assign addr      = host_req_i.addr;
  assign ram_hit   = ((addr & `RAM_MASK) == `RAM_BASE);
  assign timer_hit = ((addr & `TIMER_MASK) == `TIMER_BASE);

  // Same payload to both, strobe only to the matching window
  always_comb begin
    ram_req_o       = host_req_i;
    ram_req_o.req   = host_req_i.req & ram_hit;
    timer_req_o     = host_req_i;
    timer_req_o.req = host_req_i.req & timer_hit;
  end

  // Remember where the response will come from
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_ram_q   <= 1'b0;
      sel_timer_q <= 1'b0;
      miss_q      <= 1'b0;
    end else begin
      sel_ram_q   <= host_req_i.req & ram_hit;
      sel_timer_q <= host_req_i.req & timer_hit;
      miss_q      <= host_req_i.req & ~ram_hit & ~timer_hit;
    end
  end

  always_comb begin
    if (sel_ram_q) begin
      host_rsp_o = ram_rsp_i;
    end else if (sel_timer_q) begin
      host_rsp_o = timer_rsp_i;
    end else if (miss_q) begin
      // Unmapped address answered here
      host_rsp_o.rvalid = 1'b1;
      host_rsp_o.rdata  = '0;
      host_rsp_o.err    = 1'b1;
    end else begin
      host_rsp_o = '0;
    end
  end

endmodule

// ==== simple_sys_top.sv ====
`timescale 1ns/1ps

module simple_sys_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  simple_sys_pkg::bus_req_t host_req_i,
  output simple_sys_pkg::bus_rsp_t host_rsp_o,
  output logic                     timer_irq_o
);

  simple_sys_pkg::bus_req_t ram_req;
  simple_sys_pkg::bus_rsp_t ram_rsp;
  simple_sys_pkg::bus_req_t timer_req;
  simple_sys_pkg::bus_rsp_t timer_rsp;

  bus_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .host_req_i  (host_req_i),
    .host_rsp_o  (host_rsp_o),
    .ram_req_o   (ram_req),
    .ram_rsp_i   (ram_rsp),
    .timer_req_o (timer_req),
    .timer_rsp_i (timer_rsp)
  );

  // Data memory
  sram_word u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

  mtimer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (timer_req),
    .rsp_o       (timer_rsp),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// ==== simple_sys_asserts.sv ====
`timescale 1ns/1ps

`include "simple_sys_config.svh"

module simple_sys_asserts (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input simple_sys_pkg::bus_req_t host_req_i,
  input simple_sys_pkg::bus_rsp_t host_rsp_i,
  input logic                     timer_irq_i,
  input logic [63:0]              mtime_i,
  input logic [63:0]              mtimecmp_i
);

  import simple_sys_pkg::*;

  int unsigned fail_count = 0;
  logic        ram_hit;
  logic        timer_hit;
  logic        bad_acc;

  assign ram_hit   = ((host_req_i.addr & `RAM_MASK) == `RAM_BASE);
  assign timer_hit = ((host_req_i.addr & `TIMER_MASK) == `TIMER_BASE);
  // Timer registers sit at word offsets 0 to 3
  assign bad_acc   = !ram_hit && !(timer_hit && host_req_i.addr.regs.word < 8'd4);

  a_rsp_timing: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) host_rsp_i.rvalid == $past(host_req_i.req)
  ) else begin
    fail_count++;
    $error("rvalid does not follow the request by one cycle");
  end

  a_err: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) host_rsp_i.err == $past(host_req_i.req && bad_acc)
  ) else begin
    fail_count++;
    $error("err does not match the previous access");
  end

  // First compare result out of reset shows one cycle after release
  a_reset_quiet: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> !host_rsp_i.rvalid ##1 !timer_irq_i
  ) else begin
    fail_count++;
    $error("Interrupt or rvalid active right after reset");
  end

  a_irq: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) timer_irq_i == $past(mtime_i >= mtimecmp_i)
  ) else begin
    fail_count++;
    $error("Timer interrupt does not follow the compare by one cycle");
  end

  a_rdata_zero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      host_rsp_i.rvalid && (host_rsp_i.err || $past(host_req_i.we)) |-> host_rsp_i.rdata == '0
  ) else begin
    fail_count++;
    $error("Nonzero rdata on a write or an error response");
  end

endmodule

bind simple_sys_top simple_sys_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .host_req_i  (host_req_i),
  .host_rsp_i  (host_rsp_o),
  .timer_irq_i (timer_irq_o),
  .mtime_i     (u_timer.mtime_q),
  .mtimecmp_i  (u_timer.mtimecmp_q)
);

// ==== tb_simple_sys.sv ====
`timescale 1ns/1ps

`include "simple_sys_config.svh"

module tb_simple_sys;

  import simple_sys_pkg::*;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
  } exp_t;

  // Rough cycles per test, reset first
  localparam int RUN_CYCLES = 10 + 20 + 400 + 200 + 250 + 60 + 60;
  localparam int LIMIT      = 3 * RUN_CYCLES;
  localparam int N_WORDS    = 128;

  logic        clk_i;
  logic        rst_n_i;
  bus_req_t    host_req_i;
  bus_rsp_t    host_rsp_o;
  logic        timer_irq_o;

  logic [7:0]  shadow [4*`RAM_WORDS];
  logic [63:0] mt_base;
  int          mt_edge;
  logic [63:0] cmp_model;
  logic [31:0] lcg_state;
  exp_t        pending [$];
  exp_t        head;
  int          words [N_WORDS];
  int          edge_n;
  int          cycles = 0;
  int          n_errors;
  int          fail_mark;
  int          tests_pass;
  int          tests_fail;

  simple_sys_top dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .host_req_i  (host_req_i),
    .host_rsp_o  (host_rsp_o),
    .timer_irq_o (timer_irq_o)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected count for a read driven at edge n
  function automatic logic [63:0] mtime_at(input int n);
    return mt_base + 64'(n - mt_edge);
  endfunction

  function automatic logic [31:0] ram_word(input int w);
    return {shadow[4*w+3], shadow[4*w+2], shadow[4*w+1], shadow[4*w]};
  endfunction

  function automatic int total_fails();
    return n_errors + int'(dut0.u_asserts.fail_count);
  endfunction

  task automatic next_edge();
    @(posedge clk_i);
    edge_n++;
  endtask

  task automatic issue(input logic we, input logic [3:0] be, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [31:0] exp_rdata,
                       input logic exp_err);
    bus_req_t r;
    next_edge();
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    host_req_i <= r;
    pending.push_back(exp_t'{addr, exp_rdata, exp_err});
  endtask

  task automatic ram_write(input int w, input logic [3:0] be, input logic [31:0] data);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        shadow[4*w+b] = data[8*b +: 8];
      end
    end
    issue(1'b1, be, `RAM_BASE | 32'(w << 2), data, '0, 1'b0);
  endtask

  task automatic ram_read(input int w);
    issue(1'b0, 4'hF, `RAM_BASE | 32'(w << 2), '0, ram_word(w), 1'b0);
  endtask

  task automatic timer_access(input logic we, input logic [9:0] off, input logic [31:0] data);
    logic [63:0] now;
    logic [31:0] rd;
    logic        bad;
    now = mtime_at(edge_n + 1);
    bad = !(off inside {MTIME_LO, MTIME_HI, MTIMECMP_LO, MTIMECMP_HI});
    case (off)
      MTIME_LO:    rd = now[31:0];
      MTIME_HI:    rd = now[63:32];
      MTIMECMP_LO: rd = cmp_model[31:0];
      MTIMECMP_HI: rd = cmp_model[63:32];
      default:     rd = '0;
    endcase
    issue(we, 4'hF, `TIMER_BASE | 32'(off), data, we ? 32'h0 : rd, bad);
    if (we && !bad) begin
      if (off == MTIME_LO || off == MTIME_HI) begin
        // Loaded value shows one edge later, then counts on
        mt_base = (off == MTIME_LO) ? {now[63:32], data} : {data, now[31:0]};
        mt_edge = edge_n + 1;
      end else if (off == MTIMECMP_LO) begin
        cmp_model[31:0] = data;
      end else begin
        cmp_model[63:32] = data;
      end
    end
  endtask

  task automatic drain();
    next_edge();
    host_req_i <= '0;
    while (pending.size() != 0) begin
      next_edge();
    end
  endtask

  task automatic wait_irq(input logic level, input string what);
    int n = 0;
    while (timer_irq_o !== level && n < 40) begin
      next_edge();
      n++;
    end
    if (timer_irq_o !== level) begin
      $display("Timer interrupt did not %s within 40 cycles", what);
      n_errors++;
    end
  endtask

  task automatic end_test(input string name);
    drain();
    $display("%s: %0d failures", name, total_fails() - fail_mark);
    if (total_fails() == fail_mark) begin
      tests_pass++;
    end else begin
      tests_fail++;
    end
    fail_mark = total_fails();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Run timed out after %0d cycles with tests unfinished", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Responses come back in request order
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && host_rsp_o.rvalid === 1'b1 && pending.size() != 0) begin
      head = pending.pop_front();
      if (host_rsp_o.rdata !== head.rdata || host_rsp_o.err !== head.err) begin
        $display("Error at %0t: addr %h expected %h err %b, got %h err %b", $time,
                 head.addr, head.rdata, head.err, host_rsp_o.rdata, host_rsp_o.err);
        n_errors++;
      end
    end
  end

  initial begin
    logic [63:0] target;
    rst_n_i    = 1'b0;
    host_req_i = '0;
    lcg_state  = 32'd99;
    cmp_model  = '1;
    mt_base    = '0;
    edge_n     = 0;
    n_errors   = 0;
    fail_mark  = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (10) next_edge();
    rst_n_i <= 1'b1;
    mt_edge = edge_n;

    repeat (3) next_edge();
    timer_access(1'b0, MTIME_LO, '0);
    end_test("reset state");

    for (int i = 0; i < N_WORDS; i++) begin
      words[i] = int'((next_rand() >> 12) % `RAM_WORDS);
      ram_write(words[i], 4'(next_rand() >> 28), next_rand());
      ram_read(words[i]);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      ram_read(words[i]);
    end
    end_test("sram byte enables");

    for (int i = 0; i < 80; i++) begin
      ram_read(words[i]);
      timer_access(1'b0, MTIME_LO, '0);
    end
    end_test("response timing");

    // Low word close to wrapping so the high word carries
    timer_access(1'b1, MTIME_LO, 32'hFFFF_FFF0);
    drain();
    repeat (20) next_edge();
    timer_access(1'b0, MTIME_LO, '0);
    timer_access(1'b0, MTIME_HI, '0);
    target = mtime_at(edge_n) + 64'd12;
    timer_access(1'b1, MTIMECMP_HI, target[63:32]);
    timer_access(1'b1, MTIMECMP_LO, target[31:0]);
    drain();
    wait_irq(1'b1, "rise");
    timer_access(1'b1, MTIMECMP_LO, target[31:0] + 32'd1000);
    drain();
    wait_irq(1'b0, "fall");
    end_test("timer count and compare");

    ram_write(0, 4'hF, 32'hA5A5_0001);
    issue(1'b1, 4'hF, `RAM_BASE + 32'h1000, 32'hDEAD_BEEF, '0, 1'b1);
    issue(1'b0, 4'hF, 32'h2000_0000, '0, '0, 1'b1);
    issue(1'b1, 4'hF, `TIMER_BASE + 32'h408, 32'h0, '0, 1'b1);
    ram_read(0);
    timer_access(1'b0, MTIMECMP_LO, '0);
    timer_access(1'b0, MTIMECMP_HI, '0);
    end_test("unmapped addresses");

    timer_access(1'b1, 10'h010, 32'h0);
    timer_access(1'b0, 10'h010, '0);
    timer_access(1'b0, 10'h3FC, '0);
    timer_access(1'b0, MTIMECMP_LO, '0);
    timer_access(1'b0, MTIME_LO, '0);
    end_test("unknown timer offset");

    $display("Tests passed: %0d, failed: %0d", tests_pass, tests_fail);
    if (total_fails() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
simple_sys_pkg.sv
sram_word.sv
mtimer.sv
bus_decode.sv
simple_sys_top.sv
simple_sys_asserts.sv
tb_simple_sys.sv

// ==== Bender.yml ====
package:
  name: simple_sys

export_include_dirs:
  - .

sources:
  - simple_sys_pkg.sv
  - sram_word.sv
  - mtimer.sv
  - bus_decode.sv
  - simple_sys_top.sv
  - target: simulation
    files:
      - simple_sys_asserts.sv
      - tb_simple_sys.sv
